// ==== calc_pkg.sv ====
package calc_pkg;

    // Operand and result width
    localparam int OPERAND_WIDTH = 16;

    // Operands, results and the display value
    typedef logic [OPERAND_WIDTH-1:0] operand_t;

    // Keypad code, zero when no key is down
    typedef logic [3:0] digit_t;

    // One-hot operator select
    typedef logic [2:0] op_sel_t;

    localparam op_sel_t OP_ADD = 3'b001;
    localparam op_sel_t OP_SUB = 3'b010;
    localparam op_sel_t OP_MUL = 3'b100;

    // Sequencer states
    typedef enum logic [2:0] {
        GET_FIRST  = 3'd0,  // Digits go to operand1
        GET_SECOND = 3'd1,  // Digits go to operand2
        ISSUE      = 3'd2,  // Start pulse being set up
        WAIT_UNIT  = 3'd3,  // Unit busy
        SHOW       = 3'd4   // Result on display, complete high
    } calc_state_t;

endpackage

// ==== exec_if.sv ====
`timescale 1ns/100ps

// Request and response bundle between the sequencer and one execution unit
interface exec_if
    import calc_pkg::*;
();

    operand_t operand_a;  // Held from start until finish
    operand_t operand_b;
    logic     start;      // One-cycle request pulse
    operand_t result;     // Valid while finish is high
    logic     finish;     // One-cycle completion pulse

    modport ctrl (
        output operand_a,
        output operand_b,
        output start,
        input  result,
        input  finish
    );

    modport unit (
        input  operand_a,
        input  operand_b,
        input  start,
        output result,
        output finish
    );

endinterface

// ==== key_entry.sv ====
`timescale 1ns/100ps

module key_entry
    import calc_pkg::*;
(
    input  logic    clk,
    input  logic    nRST,
    input  digit_t  keypad_input,
    input  op_sel_t operator_input,
    input  logic    second_phase,    // High once the operator is taken
    input  logic    capture_op,
    input  logic    clear_entry,
    output logic    op_valid,
    output op_sel_t op_latched,
    output operand_t operand1,
    output operand_t operand2
);

    digit_t prev_key;  // Key code seen at the last edge
    logic   new_key;

    // Shift the operand one decimal place and append the digit
    function automatic operand_t append_digit(operand_t value, digit_t digit);
        return (value << 3) + (value << 1) + operand_t'(digit);
    endfunction

    // Rising edge of a key press only
    assign new_key = (keypad_input != '0) && (prev_key == '0);

    assign op_valid = (operator_input == OP_ADD) ||
                      (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            prev_key <= '0;
        end else begin
            prev_key <= keypad_input;
        end
    end

    // Operand accumulators
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand1 <= '0;
            operand2 <= '0;
        end else if (clear_entry) begin
            operand1 <= '0;  // Fresh start for the next entry
            operand2 <= '0;
        end else if (new_key) begin
            if (second_phase) begin
                operand2 <= append_digit(operand2, keypad_input);
            end else begin
                operand1 <= append_digit(operand1, keypad_input);
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_latched <= OP_ADD;
        end else if (capture_op) begin
            op_latched <= operator_input;
        end
    end

    // The sequencer must only ask for a capture when the code is legal
    assert property (@(posedge clk) disable iff (!nRST) capture_op |-> op_valid)
        else $error("operator captured while op_valid low");

endmodule

// ==== add_sub_unit.sv ====
`timescale 1ns/100ps

module add_sub_unit
    import calc_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    exec_if.unit bus,
    input  logic subtract  // High selects a - b
);

    operand_t sum_q;
    logic     finish_q;

    // Result register, wraps modulo 2^16
    always_ff @(posedge clk) begin
        if (bus.start) begin
            sum_q <= subtract ? (bus.operand_a - bus.operand_b)
                              : (bus.operand_a + bus.operand_b);
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish_q <= 1'b0;
        end else begin
            finish_q <= bus.start;  // Single cycle latency
        end
    end

    assign bus.result = sum_q;
    assign bus.finish = finish_q;

    // A held start would repeat the finish pulse
    assert property (@(posedge clk) disable iff (!nRST) bus.start |=> !bus.start)
        else $error("adder start held longer than one cycle");

endmodule

// ==== shift_add_multiplier.sv ====
`timescale 1ns/100ps

module shift_add_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic clk,
    input  logic nRST,
    exec_if.unit bus
);

    localparam int CNT_W = $clog2(WIDTH);

    logic [WIDTH-1:0] acc;     // Low WIDTH bits of the partial product
    logic [WIDTH-1:0] mcand;   // Multiplicand, shifted left each step
    logic [WIDTH-1:0] mplier;  // Multiplier, shifted right each step
    logic [CNT_W-1:0] count;   // Steps done so far
    logic             busy;
    logic             finish_q;
    logic             last_step;

    assign last_step = (count == CNT_W'(WIDTH - 1));

    // Datapath. The load edge already does the first step on bit 0
    always_ff @(posedge clk) begin
        if (bus.start && !busy) begin
            acc    <= bus.operand_b[0] ? bus.operand_a : '0;
            mcand  <= bus.operand_a << 1;
            mplier <= bus.operand_b >> 1;
        end else if (busy) begin
            acc    <= acc + (mplier[0] ? mcand : '0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Step counter and handshake
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            count    <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (bus.start && !busy) begin
                busy  <= 1'b1;
                count <= CNT_W'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                if (last_step) begin
                    busy     <= 1'b0;  // Final step lands with finish
                    finish_q <= 1'b1;
                end
            end
        end
    end

    assign bus.result = acc;
    assign bus.finish = finish_q;

    // Operands are held by the controller, so a second start is a protocol error
    assert property (@(posedge clk) disable iff (!nRST) busy |-> !bus.start)
        else $error("multiplier started while busy");

endmodule

// ==== calc_sequencer.sv ====
`timescale 1ns/100ps

module calc_sequencer
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  logic     equal_input,
    input  logic     op_valid,
    input  op_sel_t  op_latched,
    input  operand_t operand1,
    input  operand_t operand2,
    output logic     capture_op,
    output logic     second_phase,
    output logic     clear_entry,
    output logic     subtract,
    exec_if.ctrl     add_bus,
    exec_if.ctrl     mul_bus,
    output logic     complete,
    output operand_t display_output
);

    calc_state_t state, next_state;

    logic add_start_q;
    logic mul_start_q;
    logic unit_done;
    logic use_adder;

    assign use_adder = (op_latched == OP_ADD) || (op_latched == OP_SUB);
    assign unit_done = add_bus.finish || mul_bus.finish;

    always_comb begin
        next_state = state;
        case (state)
            GET_FIRST:  if (op_valid) next_state = GET_SECOND;
            GET_SECOND: if (equal_input) next_state = ISSUE;
            ISSUE:      next_state = WAIT_UNIT;
            WAIT_UNIT:  if (unit_done) next_state = SHOW;
            SHOW:       next_state = GET_FIRST;
            default:    next_state = GET_FIRST;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= GET_FIRST;
            add_start_q    <= 1'b0;
            mul_start_q    <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state       <= next_state;
            add_start_q <= (state == ISSUE) && use_adder;  // High in first WAIT_UNIT cycle
            mul_start_q <= (state == ISSUE) && (op_latched == OP_MUL);
            complete    <= (state == WAIT_UNIT) && unit_done;
            if ((state == WAIT_UNIT) && unit_done) begin
                display_output <= add_bus.finish ? add_bus.result : mul_bus.result;
            end
        end
    end

    // Key entry controls
    assign capture_op   = (state == GET_FIRST) && op_valid;
    assign second_phase = (state != GET_FIRST);
    assign clear_entry  = (state == SHOW);
    assign subtract     = (op_latched == OP_SUB);

    // Both units see the same operands, only one gets a start
    assign add_bus.operand_a = operand1;
    assign add_bus.operand_b = operand2;
    assign add_bus.start     = add_start_q;
    assign mul_bus.operand_a = operand1;
    assign mul_bus.operand_b = operand2;
    assign mul_bus.start     = mul_start_q;

    // Display mux assumes a single answering unit
    assert property (@(posedge clk) disable iff (!nRST)
        !(add_bus.finish && mul_bus.finish))
        else $error("both units finished in one cycle");

    // A finish outside WAIT_UNIT would be lost
    assert property (@(posedge clk) disable iff (!nRST) unit_done |-> (state == WAIT_UNIT))
        else $error("unit finish while not waiting");

endmodule

// ==== calc_top.sv ====
`timescale 1ns/100ps

module calc_top
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  digit_t   keypad_input,
    input  op_sel_t  operator_input,
    input  logic     equal_input,
    output logic     complete,
    output operand_t display_output
);

    logic     op_valid;
    logic     capture_op;
    logic     second_phase;
    logic     clear_entry;
    logic     subtract;
    op_sel_t  op_latched;
    operand_t operand1;
    operand_t operand2;

    exec_if add_bus ();  // Sequencer to adder/subtractor
    exec_if mul_bus ();  // Sequencer to multiplier

    key_entry u_key_entry (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .second_phase   (second_phase),
        .capture_op     (capture_op),
        .clear_entry    (clear_entry),
        .op_valid       (op_valid),
        .op_latched     (op_latched),
        .operand1       (operand1),
        .operand2       (operand2)
    );

    calc_sequencer u_sequencer (
        .clk            (clk),
        .nRST           (nRST),
        .equal_input    (equal_input),
        .op_valid       (op_valid),
        .op_latched     (op_latched),
        .operand1       (operand1),
        .operand2       (operand2),
        .capture_op     (capture_op),
        .second_phase   (second_phase),
        .clear_entry    (clear_entry),
        .subtract       (subtract),
        .add_bus        (add_bus),
        .mul_bus        (mul_bus),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit u_add_sub (
        .clk      (clk),
        .nRST     (nRST),
        .bus      (add_bus),
        .subtract (subtract)
    );

    shift_add_multiplier #(
        .WIDTH (OPERAND_WIDTH)
    ) u_multiplier (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus)
    );

endmodule

// ==== tb_calc.sv ====
`timescale 1ns/100ps

module tb_calc
    import calc_pkg::*;
();

    localparam int CLK_HALF     = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 8;
    localparam int DONE_TIMEOUT = 100;  // Multiplier needs about 19
    localparam int RANDOM_ROWS  = 10;

    logic     clk;
    logic     nRST;
    digit_t   keypad_input;
    op_sel_t  operator_input;
    logic     equal_input;
    logic     complete;
    operand_t display_output;

    // Stimulus table, one entry per row in each queue
    string    row_first[$];
    op_sel_t  row_op[$];
    string    row_second[$];
    operand_t row_expected[$];
    int       row_hold[$];    // Cycles each key stays down
    logic     row_bad_op[$];  // Illegal operator shown first

    int unsigned lcg_state = 82156;

    calc_top dut0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Decimal value of a digit string, wrapped to 16 bits
    function automatic operand_t digits_value(string s);
        operand_t value;
        value = '0;
        for (int i = 0; i < s.len(); i++) begin
            value = value * operand_t'(10) + operand_t'(s[i] - 8'h30);
        end
        return value;
    endfunction

    function automatic operand_t expected_result(string a, op_sel_t op, string b);
        operand_t x;
        operand_t y;
        x = digits_value(a);
        y = digits_value(b);
        case (op)
            OP_ADD:  return x + y;
            OP_SUB:  return x - y;
            default: return x * y;
        endcase
    endfunction

    function automatic void add_row(string a, op_sel_t op, string b,
                                    operand_t expected, int hold, logic bad_op);
        row_first.push_back(a);
        row_op.push_back(op);
        row_second.push_back(b);
        row_expected.push_back(expected);
        row_hold.push_back(hold);
        row_bad_op.push_back(bad_op);
    endfunction

    // One to four digits, each 1 to 9
    function automatic string random_digits();
        string s;
        int    count;
        s = "";
        count = 1 + int'(lcg_next() % 4);
        for (int i = 0; i < count; i++) begin
            s = $sformatf("%s%0d", s, 1 + lcg_next() % 9);
        end
        return s;
    endfunction

    function automatic void build_random_rows();
        string   a;
        string   b;
        op_sel_t op;
        for (int r = 0; r < RANDOM_ROWS; r++) begin
            a = random_digits();
            b = random_digits();
            case (lcg_next() % 3)
                0:       op = OP_ADD;
                1:       op = OP_SUB;
                default: op = OP_MUL;
            endcase
            add_row(a, op, b, expected_result(a, op, b), 1, 1'b0);
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic check_result(operand_t got, operand_t exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "result check failed");
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "flag check failed");
        end
    endtask

    // Press and release every digit of a string
    task automatic enter_digits(string s, int hold);
        for (int i = 0; i < s.len(); i++) begin
            keypad_input = digit_t'(s[i] - 8'h30);
            repeat (hold) next_cycle();
            keypad_input = '0;
            next_cycle();
        end
    endtask

    task automatic apply_row(int r);
        int waited;
        enter_digits(row_first[r], row_hold[r]);
        if (row_bad_op[r]) begin
            operator_input = 3'b011;  // Not one-hot, sequencer stays put
            repeat (3) next_cycle();
        end
        operator_input = row_op[r];
        next_cycle();
        enter_digits(row_second[r], row_hold[r]);
        equal_input = 1'b1;
        next_cycle();
        equal_input    = 1'b0;
        operator_input = '0;  // Gone before the return to GET_FIRST
        waited = 0;
        while (complete !== 1'b1) begin
            if (waited == DONE_TIMEOUT) begin
                $display("timeout waiting for complete");
                $display("TEST FAILED");
                $fatal(1, "no complete pulse");
            end else begin
                next_cycle();
                waited++;
            end
        end
        check_result(display_output, row_expected[r], $sformatf("row %0d display", r));
        next_cycle();
        check_flag(complete, 1'b0, $sformatf("row %0d complete one cycle later", r));
        check_result(display_output, row_expected[r], $sformatf("row %0d held display", r));
        next_cycle();
    endtask

    initial begin
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        operator_input = '0;
        equal_input    = 1'b0;
        add_row("123", OP_ADD, "45", 16'd168, 1, 1'b0);
        add_row("5", OP_SUB, "9", 16'd65532, 1, 1'b0);
        add_row("999", OP_MUL, "999", 16'd14961, 1, 1'b0);
        add_row("12", OP_MUL, "34", 16'd408, 1, 1'b0);
        add_row("65535", OP_ADD, "1", 16'd0, 1, 1'b0);
        add_row("9999", OP_MUL, "9", 16'd24455, 1, 1'b0);
        add_row("77", OP_ADD, "2", 16'd79, 4, 1'b0);  // Keys held four cycles
        add_row("42", OP_MUL, "3", 16'd126, 1, 1'b1);
        add_row("1", OP_SUB, "1", 16'd0, 1, 1'b0);
        build_random_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        nRST = 1'b1;
        next_cycle();
        check_flag(complete, 1'b0, "complete after reset");
        check_result(display_output, '0, "display after reset");
        for (int r = 0; r < row_first.size(); r++) begin
            apply_row(r);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== filelist.f ====
calc_pkg.sv
exec_if.sv
key_entry.sv
add_sub_unit.sv
shift_add_multiplier.sv
calc_sequencer.sv
calc_top.sv
tb_calc.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_calc
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
